// File: hdl/eth_csr_pkg.sv
package eth_csr_pkg;

    // ----------------------------------------
    // Channel and pair counts
    // ----------------------------------------
    localparam int NUM_CHANNELS   = 3;
    localparam int MAX_PAIRS      = 6;
    localparam int NUM_PAIRS      = (NUM_CHANNELS + 1) / 2;
    localparam int LANES_PER_PAIR = 2;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam int ADDR_W   = 12;
    localparam int DATA_W   = 32;
    localparam int OFFSET_W = 8;

    // Region in adr[11:8] and offset in adr[7:0]
    localparam int REGION_STATUS    = 0;
    localparam int REGION_PAIR_BASE = 1;

    // Pair region registers
    localparam logic [OFFSET_W-1:0] REG_CTRL   = OFFSET_W'(0);
    localparam logic [OFFSET_W-1:0] REG_COUNT0 = OFFSET_W'(1);
    localparam logic [OFFSET_W-1:0] REG_COUNT1 = OFFSET_W'(2);

    // Status region registers
    localparam logic [OFFSET_W-1:0] REG_READY  = OFFSET_W'(0);
    localparam logic [OFFSET_W-1:0] REG_LOST   = OFFSET_W'(1);

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [ADDR_W-1:0]         csr_addr_t;
    typedef logic [DATA_W-1:0]         csr_data_t;
    typedef logic [NUM_CHANNELS-1:0]   chan_vec_t;
    typedef logic [LANES_PER_PAIR-1:0] lane_vec_t;

    // Wishbone classic request from master to slave
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        csr_addr_t adr;
        csr_data_t dat;
    } wb_req_t;

    // Wishbone classic reply from slave to master
    typedef struct packed {
        logic      ack;
        csr_data_t dat;
    } wb_rsp_t;

endpackage

// File: hdl/heartbeat.sv
`timescale 1ns/1ps

module heartbeat #(
    parameter int HALF_PERIOD = 62500000
) (
    input  logic clk_125,
    input  logic rst_n,
    output logic led
);

    localparam int CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;

    logic [CNT_W-1:0] cnt;

    // Toggle once per HALF_PERIOD cycles
    always_ff @(posedge clk_125) begin
        if (!rst_n) begin
            cnt <= '0;
            led <= 1'b0;
        end else if (cnt == CNT_W'(HALF_PERIOD - 1)) begin
            cnt <= '0;
            led <= ~led;
        end else begin
            cnt <= cnt + CNT_W'(1);
        end
    end

endmodule

// File: hdl/channel_status.sv
`timescale 1ns/1ps

module channel_status (
    input  logic                   clk_125,
    input  logic                   rst_n,
    input  eth_csr_pkg::chan_vec_t channel_tx_ready,
    input  eth_csr_pkg::chan_vec_t channel_rx_ready,
    output eth_csr_pkg::chan_vec_t channel_ready_n,
    output eth_csr_pkg::chan_vec_t chan_ready,
    input  eth_csr_pkg::wb_req_t   bus_req,
    output eth_csr_pkg::wb_rsp_t   bus_rsp
);

    eth_csr_pkg::chan_vec_t           ready_now;
    eth_csr_pkg::chan_vec_t           ready_fall;
    eth_csr_pkg::chan_vec_t           lost;
    eth_csr_pkg::chan_vec_t           lost_clr;
    eth_csr_pkg::csr_data_t           rd_next;
    logic [eth_csr_pkg::OFFSET_W-1:0] offset;
    logic                             access;

    assign ready_now       = channel_tx_ready & channel_rx_ready;
    // LEDs are active low and bypass the register
    assign channel_ready_n = ~ready_now;

    // Registered bit about to drop
    assign ready_fall = chan_ready & ~ready_now;

    assign offset   = bus_req.adr[eth_csr_pkg::OFFSET_W-1:0];
    assign access   = bus_req.cyc & bus_req.stb & ~bus_rsp.ack;
    assign lost_clr = (access && bus_req.we && offset == eth_csr_pkg::REG_LOST)
                    ? bus_req.dat[eth_csr_pkg::NUM_CHANNELS-1:0] : '0;

    always_ff @(posedge clk_125) begin
        if (!rst_n) begin
            chan_ready  <= '0;
            lost        <= '0;
            bus_rsp.ack <= 1'b0;
        end else begin
            chan_ready  <= ready_now;
            // New loss beats a clear in the same cycle
            lost        <= (lost & ~lost_clr) | ready_fall;
            bus_rsp.ack <= access;
        end
    end

    always_comb begin
        case (offset)
            eth_csr_pkg::REG_READY: rd_next = eth_csr_pkg::csr_data_t'(chan_ready);
            eth_csr_pkg::REG_LOST:  rd_next = eth_csr_pkg::csr_data_t'(lost);
            default:                rd_next = '0;
        endcase
    end

    always_ff @(posedge clk_125) begin
        bus_rsp.dat <= rd_next;
    end

    assert property (@(posedge clk_125) disable iff (!rst_n)
        bus_rsp.ack |=> !bus_rsp.ack);

endmodule

// File: hdl/traffic_ctrl_pair.sv
`timescale 1ns/1ps

module traffic_ctrl_pair #(
    parameter int NUM_LANES = 2
) (
    input  logic                   clk_125,
    input  logic                   rst_n,
    input  eth_csr_pkg::lane_vec_t lane_ready,
    input  eth_csr_pkg::wb_req_t   bus_req,
    output eth_csr_pkg::wb_rsp_t   bus_rsp
);

    // Lanes that exist in this pair
    localparam eth_csr_pkg::lane_vec_t LANE_MASK = (NUM_LANES == 2) ? 2'b11 : 2'b01;
    localparam eth_csr_pkg::csr_data_t COUNT_STEP = 1;

    eth_csr_pkg::lane_vec_t           enable;
    eth_csr_pkg::lane_vec_t           count_clr;
    eth_csr_pkg::csr_data_t           count [eth_csr_pkg::LANES_PER_PAIR];
    eth_csr_pkg::csr_data_t           rd_next;
    logic [eth_csr_pkg::OFFSET_W-1:0] offset;
    logic                             access;
    logic                             wr;

    assign offset = bus_req.adr[eth_csr_pkg::OFFSET_W-1:0];
    assign access = bus_req.cyc & bus_req.stb & ~bus_rsp.ack;
    assign wr     = access & bus_req.we;

    // Any write to a count register clears it
    assign count_clr[0] = wr & (offset == eth_csr_pkg::REG_COUNT0);
    assign count_clr[1] = wr & (offset == eth_csr_pkg::REG_COUNT1);

    // ----------------------------------------
    // Enables and bus handshake
    // ----------------------------------------
    always_ff @(posedge clk_125) begin
        if (!rst_n) begin
            enable      <= '0;
            bus_rsp.ack <= 1'b0;
        end else begin
            if (wr && offset == eth_csr_pkg::REG_CTRL) begin
                enable <= bus_req.dat[eth_csr_pkg::LANES_PER_PAIR-1:0] & LANE_MASK;
            end
            bus_rsp.ack <= access;
        end
    end

    // ----------------------------------------
    // Active-cycle counters
    // ----------------------------------------
    for (genvar l = 0; l < eth_csr_pkg::LANES_PER_PAIR; l++) begin : g_lane
        if (l < NUM_LANES) begin : g_present
            always_ff @(posedge clk_125) begin
                if (!rst_n) begin
                    count[l] <= '0;
                end else if (count_clr[l]) begin
                    count[l] <= '0;
                end else if (enable[l] && lane_ready[l]) begin
                    // Wraps at 2^32
                    count[l] <= count[l] + COUNT_STEP;
                end
            end
        end else begin : g_absent
            assign count[l] = '0;
        end
    end

    always_comb begin
        case (offset)
            eth_csr_pkg::REG_CTRL:   rd_next = eth_csr_pkg::csr_data_t'(enable);
            eth_csr_pkg::REG_COUNT0: rd_next = count[0];
            eth_csr_pkg::REG_COUNT1: rd_next = count[1];
            default:                 rd_next = '0;
        endcase
    end

    always_ff @(posedge clk_125) begin
        bus_rsp.dat <= rd_next;
    end

    assert property (@(posedge clk_125) disable iff (!rst_n)
        bus_rsp.ack |=> !bus_rsp.ack);

endmodule

// File: hdl/csr_addr_decoder.sv
`timescale 1ns/1ps

module csr_addr_decoder (
    input  logic                 clk_125,
    input  logic                 rst_n,
    input  eth_csr_pkg::wb_req_t host_req,
    output eth_csr_pkg::wb_rsp_t host_rsp,
    output eth_csr_pkg::wb_req_t status_req,
    input  eth_csr_pkg::wb_rsp_t status_rsp,
    output eth_csr_pkg::wb_req_t pair_req [eth_csr_pkg::NUM_PAIRS],
    input  eth_csr_pkg::wb_rsp_t pair_rsp [eth_csr_pkg::NUM_PAIRS]
);

    // Slots beyond NUM_PAIRS exist in the map but have no block behind them
    localparam logic [eth_csr_pkg::MAX_PAIRS-1:0] SLOT_BUILT =
        {eth_csr_pkg::MAX_PAIRS{1'b1}} >> (eth_csr_pkg::MAX_PAIRS - eth_csr_pkg::NUM_PAIRS);

    logic [eth_csr_pkg::ADDR_W-eth_csr_pkg::OFFSET_W-1:0] region;
    logic                                  status_hit;
    logic [eth_csr_pkg::MAX_PAIRS-1:0]     slot_hit;
    logic [eth_csr_pkg::MAX_PAIRS-1:0]     slot_ack;
    eth_csr_pkg::csr_data_t                slot_dat [eth_csr_pkg::MAX_PAIRS];
    logic                                  mapped;
    logic                                  unmapped_ack;

    assign region     = host_req.adr[eth_csr_pkg::ADDR_W-1:eth_csr_pkg::OFFSET_W];
    assign status_hit = int'(region) == eth_csr_pkg::REGION_STATUS;
    assign mapped     = status_hit | (|(slot_hit & SLOT_BUILT));

    // Status block only sees strobes for its own region
    always_comb begin
        status_req     = host_req;
        status_req.cyc = host_req.cyc & status_hit;
        status_req.stb = host_req.stb & status_hit;
    end

    // ----------------------------------------
    // Pair slots
    // ----------------------------------------
    for (genvar k = 0; k < eth_csr_pkg::MAX_PAIRS; k++) begin : g_slot
        assign slot_hit[k] = int'(region) == eth_csr_pkg::REGION_PAIR_BASE + k;

        if (k < eth_csr_pkg::NUM_PAIRS) begin : g_built
            always_comb begin
                pair_req[k]     = host_req;
                pair_req[k].cyc = host_req.cyc & slot_hit[k];
                pair_req[k].stb = host_req.stb & slot_hit[k];
            end
            assign slot_ack[k] = pair_rsp[k].ack;
            assign slot_dat[k] = pair_rsp[k].dat;
        end else begin : g_empty
            // Answered below by the decoder itself
            assign slot_ack[k] = 1'b0;
            assign slot_dat[k] = '0;
        end
    end

    // Own one-cycle reply for anything without a target
    always_ff @(posedge clk_125) begin
        if (!rst_n) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= host_req.cyc & host_req.stb & ~mapped & ~unmapped_ack;
        end
    end

    // Reply mux selected by the held address
    always_comb begin
        host_rsp.ack = unmapped_ack;
        host_rsp.dat = '0;
        if (status_hit) begin
            host_rsp = status_rsp;
        end
        for (int k = 0; k < eth_csr_pkg::MAX_PAIRS; k++) begin
            if (slot_hit[k] && SLOT_BUILT[k]) begin
                host_rsp.ack = slot_ack[k];
                host_rsp.dat = slot_dat[k];
            end
        end
    end

    // At most one target answers in any cycle
    assert property (@(posedge clk_125) disable iff (!rst_n)
        $onehot0({status_rsp.ack, slot_ack, unmapped_ack}));

endmodule

// File: hdl/eth_csr_top.sv
`timescale 1ns/1ps

module eth_csr_top #(
    parameter int HEARTBEAT_HALF_PERIOD = 62500000
) (
    input  logic                   clk_125,
    input  logic                   rst_n,
    input  eth_csr_pkg::wb_req_t   wb_req,
    output eth_csr_pkg::wb_rsp_t   wb_rsp,
    input  eth_csr_pkg::chan_vec_t channel_tx_ready,
    input  eth_csr_pkg::chan_vec_t channel_rx_ready,
    output eth_csr_pkg::chan_vec_t channel_ready_n,
    output logic                   led_heartbeat
);

    eth_csr_pkg::wb_req_t   status_req;
    eth_csr_pkg::wb_rsp_t   status_rsp;
    eth_csr_pkg::wb_req_t   pair_req [eth_csr_pkg::NUM_PAIRS];
    eth_csr_pkg::wb_rsp_t   pair_rsp [eth_csr_pkg::NUM_PAIRS];
    eth_csr_pkg::chan_vec_t chan_ready;

    csr_addr_decoder i_csr_addr_decoder (
        .clk_125    (clk_125),
        .rst_n      (rst_n),
        .host_req   (wb_req),
        .host_rsp   (wb_rsp),
        .status_req (status_req),
        .status_rsp (status_rsp),
        .pair_req   (pair_req),
        .pair_rsp   (pair_rsp)
    );

    channel_status i_channel_status (
        .clk_125          (clk_125),
        .rst_n            (rst_n),
        .channel_tx_ready (channel_tx_ready),
        .channel_rx_ready (channel_rx_ready),
        .channel_ready_n  (channel_ready_n),
        .chan_ready       (chan_ready),
        .bus_req          (status_req),
        .bus_rsp          (status_rsp)
    );

    // ----------------------------------------
    // One traffic controller per channel pair
    // ----------------------------------------
    for (genvar p = 0; p < eth_csr_pkg::NUM_PAIRS; p++) begin : g_pair
        // Odd channel count leaves a single lane in the last pair
        localparam int LANES =
            (p == eth_csr_pkg::NUM_PAIRS - 1 && eth_csr_pkg::NUM_CHANNELS % 2 == 1) ? 1 : 2;

        eth_csr_pkg::lane_vec_t lane_ready;

        if (LANES == 2) begin : g_two
            assign lane_ready = chan_ready[2*p +: 2];
        end else begin : g_one
            assign lane_ready = {1'b0, chan_ready[2*p]};
        end

        traffic_ctrl_pair #(
            .NUM_LANES (LANES)
        ) i_traffic_ctrl_pair (
            .clk_125    (clk_125),
            .rst_n      (rst_n),
            .lane_ready (lane_ready),
            .bus_req    (pair_req[p]),
            .bus_rsp    (pair_rsp[p])
        );
    end

    heartbeat #(
        .HALF_PERIOD (HEARTBEAT_HALF_PERIOD)
    ) i_heartbeat (
        .clk_125 (clk_125),
        .rst_n   (rst_n),
        .led     (led_heartbeat)
    );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES   = 8
) (
    output logic clk_125,
    output logic rst_n
);

    initial begin
        clk_125 = 1'b0;
        forever #(HALF_PERIOD_NS) clk_125 = ~clk_125;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_125);
        rst_n <= 1'b1;
    end

endmodule

// File: tests/eth_csr_tb.sv
`timescale 1ns/1ps

module eth_csr_tb;

    localparam int HB_HALF_PERIOD  = 20;
    localparam int ACK_LIMIT       = 16;
    localparam int TEST_CYCLES     = 650;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES * 4 + 200;

    logic                   clk_125;
    logic                   rst_n;
    eth_csr_pkg::wb_req_t   wb_req;
    eth_csr_pkg::wb_rsp_t   wb_rsp;
    eth_csr_pkg::chan_vec_t channel_tx_ready;
    eth_csr_pkg::chan_vec_t channel_rx_ready;
    eth_csr_pkg::chan_vec_t channel_ready_n;
    logic                   led_heartbeat;
    integer                 seed;

    tb_clock_gen i_tb_clock_gen (
        .clk_125 (clk_125),
        .rst_n   (rst_n)
    );

    eth_csr_top #(
        .HEARTBEAT_HALF_PERIOD (HB_HALF_PERIOD)
    ) i_eth_csr_top (
        .clk_125          (clk_125),
        .rst_n            (rst_n),
        .wb_req           (wb_req),
        .wb_rsp           (wb_rsp),
        .channel_tx_ready (channel_tx_ready),
        .channel_rx_ready (channel_rx_ready),
        .channel_ready_n  (channel_ready_n),
        .led_heartbeat    (led_heartbeat)
    );

    // ----------------------------------------
    // Failure handling and compares
    // ----------------------------------------
    task automatic stop_on_failure();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_data(input string what, input eth_csr_pkg::csr_data_t got,
                              input eth_csr_pkg::csr_data_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_chan(input string what, input eth_csr_pkg::chan_vec_t got,
                              input eth_csr_pkg::chan_vec_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // ----------------------------------------
    // Wishbone master
    // ----------------------------------------
    function automatic eth_csr_pkg::csr_addr_t reg_addr(input int region,
                                                        input logic [7:0] offset);
        return {4'(region), offset};
    endfunction

    task automatic wb_access(input logic we, input eth_csr_pkg::csr_addr_t adr,
                             input eth_csr_pkg::csr_data_t wdat,
                             output eth_csr_pkg::csr_data_t rdat);
        int wait_cycles;
        @(posedge clk_125);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        wait_cycles = 0;
        do begin
            @(posedge clk_125);
            wait_cycles++;
        end while (!wb_rsp.ack && wait_cycles < ACK_LIMIT);
        if (!wb_rsp.ack) begin
            $display("no ack for the access to address %h", adr);
            stop_on_failure();
        end
        // Ack is seen on the second edge after the request goes out
        check_data("ack latency", eth_csr_pkg::csr_data_t'(wait_cycles), 2);
        rdat = wb_rsp.dat;
        wb_req <= '0;
    endtask

    task automatic wb_write(input eth_csr_pkg::csr_addr_t adr,
                            input eth_csr_pkg::csr_data_t dat);
        eth_csr_pkg::csr_data_t unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input eth_csr_pkg::csr_addr_t adr,
                           output eth_csr_pkg::csr_data_t dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    // Ready high for exactly the given number of cycles
    task automatic pulse_ready(input int chan, input int cycles);
        @(posedge clk_125);
        channel_tx_ready[chan] <= 1'b1;
        channel_rx_ready[chan] <= 1'b1;
        repeat (cycles) @(posedge clk_125);
        channel_tx_ready[chan] <= 1'b0;
        channel_rx_ready[chan] <= 1'b0;
        repeat (3) @(posedge clk_125);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic sweep_ready_patterns();
        eth_csr_pkg::chan_vec_t tx_pat [5] = '{3'b111, 3'b101, 3'b011, 3'b000, 3'b111};
        eth_csr_pkg::chan_vec_t rx_pat [5] = '{3'b111, 3'b111, 3'b110, 3'b111, 3'b001};
        // Channels ready in both directions for each pattern
        eth_csr_pkg::chan_vec_t both_pat [5] = '{3'b111, 3'b101, 3'b010, 3'b000, 3'b001};
        // Active-low LED levels for each pattern
        eth_csr_pkg::chan_vec_t led_pat [5] = '{3'b000, 3'b010, 3'b101, 3'b111, 3'b110};
        eth_csr_pkg::csr_data_t rdat;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk_125);
            channel_tx_ready <= tx_pat[i];
            channel_rx_ready <= rx_pat[i];
            @(posedge clk_125);
            check_chan("channel_ready_n", channel_ready_n, led_pat[i]);
            wb_read(reg_addr(eth_csr_pkg::REGION_STATUS, eth_csr_pkg::REG_READY), rdat);
            check_chan("REG_READY", eth_csr_pkg::chan_vec_t'(rdat), both_pat[i]);
        end
        @(posedge clk_125);
        channel_tx_ready <= '0;
        channel_rx_ready <= '0;
        repeat (3) @(posedge clk_125);
    endtask

    task automatic set_and_clear_lost_flags();
        eth_csr_pkg::csr_addr_t lost_adr;
        eth_csr_pkg::csr_data_t rdat;
        lost_adr = reg_addr(eth_csr_pkg::REGION_STATUS, eth_csr_pkg::REG_LOST);
        // Drops during the LED patterns leave flags behind
        wb_write(lost_adr, 32'h7);
        wb_read(lost_adr, rdat);
        check_chan("REG_LOST after clear all", eth_csr_pkg::chan_vec_t'(rdat), 3'b000);
        pulse_ready(1, 4);
        wb_read(lost_adr, rdat);
        check_chan("REG_LOST after channel 1 drop", eth_csr_pkg::chan_vec_t'(rdat), 3'b010);
        wb_write(lost_adr, 32'h2);
        wb_read(lost_adr, rdat);
        check_chan("REG_LOST after clear", eth_csr_pkg::chan_vec_t'(rdat), 3'b000);
    endtask

    task automatic count_enabled_cycles();
        int                     n;
        eth_csr_pkg::csr_data_t rdat;
        n = 1 + int'($unsigned($random(seed)) % 24);
        wb_write(reg_addr(1, eth_csr_pkg::REG_CTRL), 32'h1);
        pulse_ready(0, n);
        wb_read(reg_addr(1, eth_csr_pkg::REG_COUNT0), rdat);
        check_data("pair 0 count 0 enabled", rdat, eth_csr_pkg::csr_data_t'(n));
        wb_write(reg_addr(1, eth_csr_pkg::REG_CTRL), 32'h0);
        pulse_ready(0, n);
        wb_read(reg_addr(1, eth_csr_pkg::REG_COUNT0), rdat);
        check_data("pair 0 count 0 disabled", rdat, eth_csr_pkg::csr_data_t'(n));
        wb_write(reg_addr(1, eth_csr_pkg::REG_COUNT0), 32'h1234);
        wb_read(reg_addr(1, eth_csr_pkg::REG_COUNT0), rdat);
        check_data("pair 0 count 0 cleared", rdat, 32'h0);
    endtask

    // Pair 1 has only lane 0 and channel 2 feeds it
    task automatic probe_odd_pair(output int m);
        eth_csr_pkg::csr_data_t rdat;
        m = 1 + int'($unsigned($random(seed)) % 24);
        wb_write(reg_addr(2, eth_csr_pkg::REG_CTRL), 32'h3);
        wb_read(reg_addr(2, eth_csr_pkg::REG_CTRL), rdat);
        check_data("pair 1 enables", rdat, 32'h1);
        wb_write(reg_addr(2, eth_csr_pkg::REG_COUNT1), 32'hffff_ffff);
        pulse_ready(2, m);
        wb_read(reg_addr(2, eth_csr_pkg::REG_COUNT1), rdat);
        check_data("pair 1 count 1", rdat, 32'h0);
        wb_read(reg_addr(2, eth_csr_pkg::REG_COUNT0), rdat);
        check_data("pair 1 count 0", rdat, eth_csr_pkg::csr_data_t'(m));
    endtask

    task automatic access_unmapped_regions(input int pair1_count);
        eth_csr_pkg::csr_data_t rdat;
        // A stray write to pair 1 would set its enable again
        wb_write(reg_addr(2, eth_csr_pkg::REG_CTRL), 32'h0);
        for (int r = 3; r < 16; r++) begin
            wb_write(reg_addr(r, 8'h00), 32'hffff_ffff);
            wb_write(reg_addr(r, 8'h01), 32'hffff_ffff);
            wb_read(reg_addr(r, 8'h00), rdat);
            check_data($sformatf("unmapped region %0d", r), rdat, 32'h0);
        end
        // Mapped registers keep what the earlier tests left
        wb_read(reg_addr(1, eth_csr_pkg::REG_CTRL), rdat);
        check_data("pair 0 enables after unmapped", rdat, 32'h0);
        wb_read(reg_addr(2, eth_csr_pkg::REG_CTRL), rdat);
        check_data("pair 1 enables after unmapped", rdat, 32'h0);
        wb_read(reg_addr(2, eth_csr_pkg::REG_COUNT0), rdat);
        check_data("pair 1 count 0 after unmapped", rdat,
                   eth_csr_pkg::csr_data_t'(pair1_count));
        wb_read(reg_addr(eth_csr_pkg::REGION_STATUS, eth_csr_pkg::REG_LOST), rdat);
        check_chan("REG_LOST after unmapped", eth_csr_pkg::chan_vec_t'(rdat), 3'b101);
    endtask

    task automatic time_heartbeat();
        logic prev;
        int   cycles;
        prev = led_heartbeat;
        for (int t = 0; t < 4; t++) begin
            cycles = 0;
            do begin
                @(posedge clk_125);
                cycles++;
            end while (led_heartbeat === prev && cycles < 5 * HB_HALF_PERIOD);
            if (led_heartbeat === prev) begin
                $display("heartbeat LED stopped toggling");
                stop_on_failure();
            end
            check_bit("led_heartbeat", led_heartbeat, ~prev);
            // First interval starts at an arbitrary point
            if (t > 0) begin
                check_data("heartbeat half period", eth_csr_pkg::csr_data_t'(cycles),
                           eth_csr_pkg::csr_data_t'(HB_HALF_PERIOD));
            end
            prev = led_heartbeat;
        end
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        int pair1_count;
        seed             = 27399;
        wb_req           = '0;
        channel_tx_ready = '0;
        channel_rx_ready = '0;
        while (rst_n !== 1'b1) @(posedge clk_125);
        check_bit("led_heartbeat after reset", led_heartbeat, 1'b0);
        sweep_ready_patterns();
        set_and_clear_lost_flags();
        count_enabled_cycles();
        probe_odd_pair(pair1_count);
        access_unmapped_regions(pair1_count);
        time_heartbeat();
        $display("TB PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_125);
        $display("watchdog expired before the tests finished");
        stop_on_failure();
    end

endmodule

// File: src.f
hdl/eth_csr_pkg.sv
hdl/heartbeat.sv
hdl/channel_status.sv
hdl/traffic_ctrl_pair.sv
hdl/csr_addr_decoder.sv
hdl/eth_csr_top.sv
tests/tb_clock_gen.sv
tests/eth_csr_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := eth_csr_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
